/* include/audio_cfg.svh */
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// all durations below are in clock cycles.
// values are kept small so a full effect runs quickly in simulation.

// jump chirp.
`define JUMP_CYCLES      120   // length of the whole chirp.
`define JUMP_START_HALF  12    // first half-period of the chirp.
`define JUMP_MIN_HALF    4     // chirp stops speeding up here.

// win and lose tunes.
`define NOTE_CYCLES      64    // length of one note.
`define NOTE_COUNT       4     // notes per tune.

// a tune lasts exactly its notes back to back.
`define MELODY_CYCLES    (`NOTE_CYCLES * `NOTE_COUNT)

// counter widths.
`define TIMER_WIDTH      9     // holds MELODY_CYCLES - 1.
`define HALF_WIDTH       5     // holds the largest half-period.

`endif

/* src/audioPkg.sv */
package audioPkg;

    // which effect the unit is playing right now.
    // none means the speaker output is held low.
    typedef enum logic [1:0] {
        none,       // silent.
        jumpSound,  // rising chirp.
        winSound,   // ascending four-note tune.
        loseSound   // descending four-note tune.
    } soundKind;

endpackage

/* src/melodyRom.sv */
`timescale 1ns/10ps

`include "audio_cfg.svh"

module melodyRom (
    input  logic                   loseTune,
    input  logic [1:0]             noteIndex,
    output logic [`HALF_WIDTH-1:0] halfPeriod
);

    // half-periods in cycles.
    // a smaller value is a higher note.
    always_comb begin
        case ({loseTune, noteIndex})
            // win tune climbs.
            3'b000:  halfPeriod = `HALF_WIDTH'(10);
            3'b001:  halfPeriod = `HALF_WIDTH'(8);
            3'b010:  halfPeriod = `HALF_WIDTH'(6);
            3'b011:  halfPeriod = `HALF_WIDTH'(5);
            // lose tune falls.
            3'b100:  halfPeriod = `HALF_WIDTH'(5);
            3'b101:  halfPeriod = `HALF_WIDTH'(7);
            3'b110:  halfPeriod = `HALF_WIDTH'(9);
            default: halfPeriod = `HALF_WIDTH'(12);
        endcase
    end

endmodule

/* src/jumpSweep.sv */
`timescale 1ns/10ps

`include "audio_cfg.svh"

module jumpSweep (
    input  logic clk,
    input  logic rstN,
    input  logic jumpEnable,
    input  logic restart,
    output logic jumpWave
);

    localparam int halfW = `HALF_WIDTH;

    localparam logic [halfW-1:0] startHalf = halfW'(`JUMP_START_HALF);
    localparam logic [halfW-1:0] minHalf   = halfW'(`JUMP_MIN_HALF);

    logic [halfW-1:0] halfPeriod;  // length of the current phase.
    logic [halfW-1:0] phaseCnt;    // cycles already spent in this phase.
    logic             wave;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halfPeriod <= startHalf;
            phaseCnt   <= '0;
            wave       <= 1'b0;
        end else if (restart) begin
            halfPeriod <= startHalf;
            phaseCnt   <= halfW'(1);   // restart cycle is the first low cycle.
            wave       <= 1'b0;
        end else if (jumpEnable) begin
            if (phaseCnt == halfPeriod - halfW'(1)) begin
                wave     <= ~wave;
                phaseCnt <= '0;
                // pitch rises until the floor is reached.
                if (halfPeriod > minHalf) begin
                    halfPeriod <= halfPeriod - halfW'(1);
                end
            end else begin
                phaseCnt <= phaseCnt + halfW'(1);
            end
        end else begin
            wave <= 1'b0;   // idle low until the next restart.
        end
    end

    // an override may arrive while the wave is high.
    assign jumpWave = wave & ~restart;

endmodule

/* src/melodyPlayer.sv */
`timescale 1ns/10ps

`include "audio_cfg.svh"

module melodyPlayer (
    input  logic               clk,
    input  logic               rstN,
    input  logic               melodyEnable,
    input  logic               restart,
    input  audioPkg::soundKind activeSound,
    output logic               melodyWave
);

    localparam int halfW = `HALF_WIDTH;
    localparam int noteW = $clog2(`NOTE_CYCLES);

    localparam logic [noteW-1:0] noteLast = noteW'(`NOTE_CYCLES - 1);

    logic             loseTune;
    logic [1:0]       noteIdx;
    logic [noteW-1:0] noteCnt;     // cycles already spent in this note.
    logic [halfW-1:0] halfPeriod;  // from the tune table.
    logic [halfW-1:0] halfCnt;
    logic             wave;

    assign loseTune = (activeSound == audioPkg::loseSound);

    melodyRom i_melodyRom (
        .loseTune   (loseTune),
        .noteIndex  (noteIdx),
        .halfPeriod (halfPeriod)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            noteIdx <= '0;
            noteCnt <= '0;
            halfCnt <= '0;
            wave    <= 1'b0;
        end else if (restart) begin
            noteIdx <= '0;
            noteCnt <= noteW'(1);    // restart cycle opens the first note.
            halfCnt <= halfW'(1);
            wave    <= 1'b0;
        end else if (melodyEnable) begin
            if (noteCnt == noteLast) begin
                // next note starts with a fresh low phase.
                noteCnt <= '0;
                halfCnt <= '0;
                wave    <= 1'b0;
                noteIdx <= noteIdx + 2'd1;   // wraps after the last note.
            end else begin
                noteCnt <= noteCnt + noteW'(1);
                if (halfCnt == halfPeriod - halfW'(1)) begin
                    wave    <= ~wave;
                    halfCnt <= '0;
                end else begin
                    halfCnt <= halfCnt + halfW'(1);
                end
            end
        end else begin
            wave <= 1'b0;   // idle low.
        end
    end

    // keep the restart cycle low even when a tune is overridden mid-phase.
    assign melodyWave = wave & ~restart;

endmodule

/* src/soundSequencer.sv */
`timescale 1ns/10ps

`include "audio_cfg.svh"

module soundSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 jumpForward,
    input  logic                 jumpBackward,
    input  logic                 jumpRight,
    input  logic                 jumpLeft,
    input  logic                 winIn,
    input  logic                 loseIn,
    input  logic                 jumpWave,
    input  logic                 melodyWave,
    output audioPkg::soundKind   activeSound,
    output logic                 jumpEnable,
    output logic                 melodyEnable,
    output logic                 restart,
    output logic                 sound
);

    localparam int timerW = `TIMER_WIDTH;

    localparam logic [timerW-1:0] jumpLoad   = timerW'(`JUMP_CYCLES - 1);
    localparam logic [timerW-1:0] melodyLoad = timerW'(`MELODY_CYCLES - 1);

    logic              anyJump;
    logic              jumpPrev;
    logic              winPrev;
    logic              losePrev;
    logic              jumpEdge;
    logic              winEdge;
    logic              loseEdge;
    logic              trigger;
    logic [timerW-1:0] timer;     // cycles left after the current one.

    assign anyJump = jumpForward | jumpBackward | jumpRight | jumpLeft;

    // rising edges only, so a held button plays once.
    assign jumpEdge = anyJump & ~jumpPrev;
    assign winEdge  = winIn & ~winPrev;
    assign loseEdge = loseIn & ~losePrev;
    assign trigger  = jumpEdge | winEdge | loseEdge;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            jumpPrev <= 1'b0;     // a level high out of reset counts as an edge.
            winPrev  <= 1'b0;
            losePrev <= 1'b0;
        end else begin
            jumpPrev <= anyJump;
            winPrev  <= winIn;
            losePrev <= loseIn;
        end
    end

    // the newest accepted trigger always takes over the speaker.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            activeSound <= audioPkg::none;
            timer       <= '0;
            restart     <= 1'b0;
        end else begin
            restart <= trigger;   // first active cycle of a new effect.
            if (jumpEdge) begin
                activeSound <= audioPkg::jumpSound;
                timer       <= jumpLoad;
            end else if (winEdge) begin
                activeSound <= audioPkg::winSound;
                timer       <= melodyLoad;
            end else if (loseEdge) begin
                activeSound <= audioPkg::loseSound;
                timer       <= melodyLoad;
            end else if (activeSound != audioPkg::none) begin
                if (timer == '0) begin
                    activeSound <= audioPkg::none;  // effect is over.
                end else begin
                    timer <= timer - timerW'(1);
                end
            end
        end
    end

    // enables and output routing follow the latched kind.
    always_comb begin
        jumpEnable   = 1'b0;
        melodyEnable = 1'b0;
        sound        = 1'b0;
        case (activeSound)
            audioPkg::jumpSound: begin
                jumpEnable = 1'b1;
                sound      = jumpWave;
            end
            audioPkg::winSound,
            audioPkg::loseSound: begin
                melodyEnable = 1'b1;   // tune choice is made by the player.
                sound        = melodyWave;
            end
            default: begin
                sound = 1'b0;          // silent.
            end
        endcase
    end

endmodule

/* src/soundEffects.sv */
`timescale 1ns/10ps

module soundEffects (
    input  logic clk,
    input  logic rstN,
    input  logic jumpForward,
    input  logic jumpBackward,
    input  logic jumpRight,
    input  logic jumpLeft,
    input  logic winIn,
    input  logic loseIn,
    output logic sound
);

    audioPkg::soundKind activeSound;
    logic               jumpEnable;
    logic               melodyEnable;
    logic               restart;
    logic               jumpWave;
    logic               melodyWave;

    // triggers, timing and output select.
    soundSequencer i_soundSequencer (
        .clk          (clk),
        .rstN         (rstN),
        .jumpForward  (jumpForward),
        .jumpBackward (jumpBackward),
        .jumpRight    (jumpRight),
        .jumpLeft     (jumpLeft),
        .winIn        (winIn),
        .loseIn       (loseIn),
        .jumpWave     (jumpWave),
        .melodyWave   (melodyWave),
        .activeSound  (activeSound),
        .jumpEnable   (jumpEnable),
        .melodyEnable (melodyEnable),
        .restart      (restart),
        .sound        (sound)
    );

    jumpSweep i_jumpSweep (
        .clk        (clk),
        .rstN       (rstN),
        .jumpEnable (jumpEnable),
        .restart    (restart),
        .jumpWave   (jumpWave)
    );

    // shared by the win and lose tunes.
    melodyPlayer i_melodyPlayer (
        .clk          (clk),
        .rstN         (rstN),
        .melodyEnable (melodyEnable),
        .restart      (restart),
        .activeSound  (activeSound),
        .melodyWave   (melodyWave)
    );

endmodule

/* tb/soundEffectsTb.sv */
`timescale 1ns/10ps

`include "audio_cfg.svh"

module soundEffectsTb;

    logic clk;
    logic rstN;
    logic jumpForward;
    logic jumpBackward;
    logic jumpRight;
    logic jumpLeft;
    logic winIn;
    logic loseIn;
    logic sound;

    // stimulus table, one entry per test step.
    logic [5:0] stimPattern[$];   // {lose, win, left, right, backward, forward}.
    int         stimCycles[$];
    int         stimPulses[$];    // rising edges of sound expected, -1 when not counted.
    string      stimName[$];

    // tune half-periods, ascending then descending pitch.
    int winHalf[4]  = '{10, 8, 6, 5};
    int loseHalf[4] = '{5, 7, 9, 12};

    // reference model state.
    logic               mPrevJump;
    logic               mPrevWin;
    logic               mPrevLose;
    audioPkg::soundKind mKind;
    int                 mLeft;     // active cycles left, the current one included.
    int                 mAge;      // cycles since the restart cycle.
    int                 mHalf;
    int                 mPos;
    logic               mLevel;

    int     errorCount;
    int     checkCount;
    int     testErrors;
    int     pulses;
    logic   lastSound;
    int     cycleCount;
    int     cycleLimit;
    integer seed;

    soundEffects i_soundEffects (
        .clk          (clk),
        .rstN         (rstN),
        .jumpForward  (jumpForward),
        .jumpBackward (jumpBackward),
        .jumpRight    (jumpRight),
        .jumpLeft     (jumpLeft),
        .winIn        (winIn),
        .loseIn       (loseIn),
        .sound        (sound)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // guards against a run that never reaches the end of the table.
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic addStep(input logic [5:0] pattern, input int cycles, input int expPulses,
                           input string name);
        stimPattern.push_back(pattern);
        stimCycles.push_back(cycles);
        stimPulses.push_back(expPulses);
        stimName.push_back(name);
    endtask

    task automatic driveInputs(input logic [5:0] pattern);
        {loseIn, winIn, jumpLeft, jumpRight, jumpBackward, jumpForward} = pattern;
    endtask

    task automatic startEffect(input audioPkg::soundKind kind, input int cycles);
        mKind  = kind;
        mLeft  = cycles;
        mAge   = 0;
        mHalf  = `JUMP_START_HALF;
        mPos   = 0;
        mLevel = 1'b0;   // every effect opens with a low cycle.
    endtask

    // one clock edge of the model, with the inputs sampled at that edge.
    task automatic updateModel(input logic [5:0] pattern);
        logic jumpNow;
        logic jumpEdge;
        logic winEdge;
        logic loseEdge;
        jumpNow   = |pattern[3:0];
        jumpEdge  = jumpNow & ~mPrevJump;
        winEdge   = pattern[4] & ~mPrevWin;
        loseEdge  = pattern[5] & ~mPrevLose;
        mPrevJump = jumpNow;
        mPrevWin  = pattern[4];
        mPrevLose = pattern[5];
        if (jumpEdge) begin
            startEffect(audioPkg::jumpSound, `JUMP_CYCLES);
        end else if (winEdge) begin
            startEffect(audioPkg::winSound, `MELODY_CYCLES);
        end else if (loseEdge) begin
            startEffect(audioPkg::loseSound, `MELODY_CYCLES);
        end else if (mKind != audioPkg::none) begin
            mLeft--;
            mAge++;
            if (mLeft == 0) begin
                mKind = audioPkg::none;
            end
            // chirp phase, each half-period one cycle shorter than the last.
            mPos++;
            if (mPos == mHalf) begin
                mLevel = ~mLevel;
                mPos   = 0;
                if (mHalf > `JUMP_MIN_HALF) begin
                    mHalf--;
                end
            end
        end
    endtask

    function automatic logic modelSound();
        int   note;
        int   pos;
        logic result;
        note   = mAge / `NOTE_CYCLES;
        pos    = mAge % `NOTE_CYCLES;   // each note starts a fresh low phase.
        result = 1'b0;
        case (mKind)
            audioPkg::jumpSound: result = mLevel;
            audioPkg::winSound:  result = ((pos / winHalf[note]) % 2) == 1;
            audioPkg::loseSound: result = ((pos / loseHalf[note]) % 2) == 1;
            default:             result = 1'b0;
        endcase
        return result;
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string name, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            testErrors++;
            $display("error at %0t: %s: %s expected %0d, got %0d",
                     $time, name, what, exp, got);
        end
    endtask

    task automatic runCycle(input logic [5:0] pattern, input string name);
        logic expSound;
        @(posedge clk);
        updateModel({loseIn, winIn, jumpLeft, jumpRight, jumpBackward, jumpForward});
        #2;
        driveInputs(pattern);
        #8;
        expSound = modelSound();
        checkValue({31'b0, sound}, {31'b0, expSound}, name, "sound");
        if (sound === 1'b1 && lastSound === 1'b0) begin
            pulses++;
        end
        lastSound = sound;
    endtask

    initial begin
        int         totalCycles;
        logic [5:0] dir;
        int         press;
        int         gap;
        $timeformat(-9, 0, " ns", 0);
        rstN = 1'b0;
        driveInputs(6'b0);
        mPrevJump  = 1'b0;
        mPrevWin   = 1'b0;
        mPrevLose  = 1'b0;
        mKind      = audioPkg::none;
        mLeft      = 0;
        mAge       = 0;
        mHalf      = `JUMP_START_HALF;
        mPos       = 0;
        mLevel     = 1'b0;
        errorCount = 0;
        checkCount = 0;
        lastSound  = 1'b0;
        cycleCount = 0;
        seed       = 32'hd3536e58;

        // the first cycle of each entry still shows the previous step.
        addStep(6'b000000, 50, 0, "idle after reset");
        addStep(6'b000001, 130, 10, "jump forward");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b000010, 130, 10, "jump backward");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b000100, 130, 10, "jump right");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b001000, 130, 10, "jump left");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b010000, 265, 18, "win tune");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b100000, 265, 18, "lose tune");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b010000, 40, -1, "win before jump");
        addStep(6'b010001, 130, 10, "jump over win");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b000001, 30, -1, "jump before win");
        addStep(6'b010001, 265, 18, "win over jump");
        addStep(6'b000000, 10, 0, "gap");
        addStep(6'b110001, 130, 10, "all at once");
        addStep(6'b000000, 10, 0, "gap");

        // short gaps land re-presses inside a running chirp.
        for (int i = 0; i < 12; i++) begin
            dir   = 6'(1 << ({$random(seed)} % 4));
            press = 3 + {$random(seed)} % 20;
            gap   = 1 + {$random(seed)} % 150;
            addStep(dir, press, -1, $sformatf("random press %0d", i));
            addStep(6'b000000, gap, -1, $sformatf("random gap %0d", i));
        end
        addStep(6'b000000, 130, -1, "final silence");

        totalCycles = 0;
        foreach (stimCycles[i]) begin
            totalCycles += stimCycles[i];
        end
        cycleLimit = totalCycles + 100;

        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;

        for (int i = 0; i < stimPattern.size(); i++) begin
            testErrors = 0;
            pulses     = 0;
            for (int c = 0; c < stimCycles[i]; c++) begin
                runCycle(stimPattern[i], stimName[i]);
            end
            if (stimPulses[i] >= 0) begin
                checkValue(32'(pulses), 32'(stimPulses[i]), stimName[i], "sound pulses");
            end
            $display("test %-18s %4d cycles, %0d pulses, %0d errors",
                     stimName[i], stimCycles[i], pulses, testErrors);
        end

        $display("%0d tests, %0d checks, %0d errors", stimPattern.size(), checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
src/audioPkg.sv
src/melodyRom.sv
src/jumpSweep.sv
src/melodyPlayer.sv
src/soundSequencer.sv
src/soundEffects.sv
tb/soundEffectsTb.sv

/* Makefile */
# Verilator build and run for the sound effects unit.
# Any variable below can be overridden, e.g. make test OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= soundEffectsTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
